// ==== hw/gpu_ram_pkg.sv ====
package gpu_ram_pkg;

	localparam int NUM_PORTS      = 5;      // video ports, also clk cycles per pixel
	localparam int ADDR_W         = 20;     // video and host address width
	localparam int CMD_W          = 32;     // per-port command word
	localparam int PIX_W          = 16;     // video data word
	localparam int HOST_W         = 8;      // host data byte
	localparam int PHASE_W        = 3;      // enough for phases 0..NUM_PORTS-1

	localparam int RAM_ADDR_SIZE  = 11;     // byte address bits, 2 KB window
	localparam int RAM_WORDS      = 2 ** (RAM_ADDR_SIZE - 1); // 16-bit words in the RAM
	localparam int LANE_W         = RAM_ADDR_SIZE - 1;        // word index width

	// host window base, low RAM_ADDR_SIZE bits must stay zero
	localparam logic [ADDR_W-1:0] HOST_BASE_ADDRESS = 20'h0_8000;

	localparam int PIXEL_PIPE     = 3;      // pixel periods from sample to output
	localparam int CLK_CYCLES_MUX = 1;      // port_mux register stage
	localparam int CLK_CYCLES_RAM = 2;      // video read stages inside the RAM

	// pipe top so that port 0 sits here on the capture edge, port k at top-k
	localparam int DEMUX_PIPE_TOP = (((PIXEL_PIPE - 1) * NUM_PORTS) - 1)
		- CLK_CYCLES_MUX - CLK_CYCLES_RAM;

	localparam int FILL_W         = $clog2(PIXEL_PIPE + 1); // saturating fill counter

	typedef logic [ADDR_W-1:0]  addr_t;      // video or host address
	typedef logic [CMD_W-1:0]   cmd_t;       // command word, passed through untouched
	typedef logic [PIX_W-1:0]   pix_t;       // two bytes, even byte in the low lane
	typedef logic [HOST_W-1:0]  host_byte_t; // host data byte
	typedef logic [PHASE_W-1:0] phase_t;     // pixel phase index

endpackage

// ==== hw/pixel_phase_ctrl.sv ====
`timescale 1ns/10ps

module pixel_phase_ctrl (
	input  logic                clk,
	input  logic                reset,
	output gpu_ram_pkg::phase_t phase,        // which port owns the RAM this cycle
	output logic                pixel_start,  // phase 0, new sample edge
	output logic                pix_valid     // one cycle after each valid output update
);

	localparam int FILL_W = gpu_ram_pkg::FILL_W;

	logic [FILL_W-1:0] fill_cnt;   // pixel starts seen so far, saturates
	logic [FILL_W-1:0] fill_nxt;   // count including the start at this edge

	assign pixel_start = (phase == '0);

	always_comb begin
		fill_nxt = fill_cnt;
		if (pixel_start && (fill_cnt != FILL_W'(gpu_ram_pkg::PIXEL_PIPE))) begin
			fill_nxt = fill_cnt + 1'b1; // stop counting once filled
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase     <= '0;
			fill_cnt  <= '0;
			pix_valid <= 1'b0;
		end else begin
			if (phase == gpu_ram_pkg::phase_t'(gpu_ram_pkg::NUM_PORTS - 1)) begin
				phase <= '0;            // wrap 4 -> 0
			end else begin
				phase <= phase + 1'b1;
			end
			fill_cnt <= fill_nxt;
			// the PIXEL_PIPE-th start is the first edge that loads real results
			pix_valid <= pixel_start && (fill_nxt == FILL_W'(gpu_ram_pkg::PIXEL_PIPE));
		end
	end

	// phase must stay inside the port range or the mux picks a missing latch
	a_phase_range: assert property (@(posedge clk) disable iff (reset)
		phase <= gpu_ram_pkg::phase_t'(gpu_ram_pkg::NUM_PORTS - 1));

endmodule

// ==== hw/port_mux.sv ====
`timescale 1ns/10ps

module port_mux (
	input  logic                clk,
	input  logic                reset,
	input  gpu_ram_pkg::phase_t phase,
	input  logic                pixel_start,
	input  gpu_ram_pkg::addr_t  addr_in [gpu_ram_pkg::NUM_PORTS], // sampled at pixel start
	input  gpu_ram_pkg::cmd_t   cmd_in  [gpu_ram_pkg::NUM_PORTS],
	output gpu_ram_pkg::addr_t  ram_addr,   // one port per cycle toward the RAM
	output gpu_ram_pkg::cmd_t   ram_cmd
);

	localparam int LAST = gpu_ram_pkg::NUM_PORTS - 1;

	gpu_ram_pkg::addr_t addr_lat [1:LAST]; // ports 1..4 held for the rest of the pixel
	gpu_ram_pkg::cmd_t  cmd_lat  [1:LAST];

	// latches only, loaded once per pixel
	always_ff @(posedge clk) begin
		if (pixel_start) begin
			for (int k = 1; k <= LAST; k++) begin
				addr_lat[k] <= addr_in[k];
				cmd_lat[k]  <= cmd_in[k];
			end
		end
	end

	// RAM request register, port k leaves on the edge where phase == k
	always_ff @(posedge clk) begin
		if (reset) begin
			ram_addr <= '0;
			ram_cmd  <= '0;
		end else if (pixel_start) begin
			ram_addr <= addr_in[0];     // port 0 straight from the inputs
			ram_cmd  <= cmd_in[0];
		end else begin
			ram_addr <= addr_lat[phase]; // phase 1..4 here
			ram_cmd  <= cmd_lat[phase];
		end
	end

	// pixel_start comes from the controller and must track phase 0 exactly
	a_start_is_phase0: assert property (@(posedge clk) disable iff (reset)
		pixel_start == (phase == '0));

	// every pixel period runs through all phases before the next start
	a_start_period: assert property (@(posedge clk) disable iff (reset)
		pixel_start |=> !pixel_start [* LAST] ##1 pixel_start);

endmodule

// ==== hw/gpu_dual_port_ram.sv ====
`timescale 1ns/10ps

module gpu_dual_port_ram (
	input  logic                    clk,
	input  gpu_ram_pkg::addr_t      video_addr,      // byte address, bit 0 ignored
	input  gpu_ram_pkg::cmd_t       video_cmd,
	output gpu_ram_pkg::addr_t      video_addr_out,  // aligned with video_data
	output gpu_ram_pkg::cmd_t       video_cmd_out,
	output gpu_ram_pkg::pix_t       video_data,
	input  gpu_ram_pkg::addr_t      host_addr,
	input  logic                    host_wr,
	input  gpu_ram_pkg::host_byte_t host_wdata,
	output gpu_ram_pkg::host_byte_t host_rdata
);

	localparam int AW     = gpu_ram_pkg::ADDR_W;
	localparam int RS     = gpu_ram_pkg::RAM_ADDR_SIZE;
	localparam int LANE_W = gpu_ram_pkg::LANE_W;
	localparam int HW     = gpu_ram_pkg::HOST_W;

	gpu_ram_pkg::pix_t mem [gpu_ram_pkg::RAM_WORDS]; // even byte low, odd byte high

	logic [LANE_W-1:0] video_word;  // word index from byte address
	logic [LANE_W-1:0] host_word;
	logic              host_lane;   // 0 = low byte, 1 = high byte
	logic              host_in_win; // upper bits match the window base
	logic              host_we;

	gpu_ram_pkg::pix_t  rd_word_q;  // first read stage
	gpu_ram_pkg::addr_t rd_addr_q;
	gpu_ram_pkg::cmd_t  rd_cmd_q;

	assign video_word  = video_addr[RS-1:1];
	assign host_word   = host_addr[RS-1:1];
	assign host_lane   = host_addr[0];
	assign host_in_win = (host_addr[AW-1:RS] == gpu_ram_pkg::HOST_BASE_ADDRESS[AW-1:RS]);
	assign host_we     = host_wr && host_in_win;  // no writes outside the window

	// host side, one byte lane per write
	always_ff @(posedge clk) begin
		if (host_we) begin
			mem[host_word][host_lane*HW +: HW] <= host_wdata;
		end
		if (host_in_win) begin
			host_rdata <= mem[host_word][host_lane*HW +: HW]; // old byte on a write
		end else begin
			host_rdata <= '0;   // outside window reads as zero
		end
	end

	// video side, two register stages, address and command ride along
	always_ff @(posedge clk) begin
		rd_word_q      <= mem[video_word]; // same-cycle host write gives the old word
		rd_addr_q      <= video_addr;
		rd_cmd_q       <= video_cmd;
		video_data     <= rd_word_q;
		video_addr_out <= rd_addr_q;
		video_cmd_out  <= rd_cmd_q;
	end

endmodule

// ==== hw/realign_pipe.sv ====
`timescale 1ns/10ps

module realign_pipe #(
	parameter type payload_t = gpu_ram_pkg::pix_t  // data, address or command
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     capture,                        // pixel start
	input  payload_t din,                            // serial results from the RAM
	output payload_t dout [gpu_ram_pkg::NUM_PORTS]   // port order, held between captures
);

	localparam int TOP = gpu_ram_pkg::DEMUX_PIPE_TOP;

	payload_t pipe [TOP:0];  // entry 0 newest

	// shift every cycle, the pipeline never stalls
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i <= TOP; i++) begin
				pipe[i] <= '0;  // keeps early captures at zero
			end
		end else begin
			pipe[0] <= din;
			for (int i = 1; i <= TOP; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	// port 0 is the oldest entry on a capture edge, port k sits k places below
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < gpu_ram_pkg::NUM_PORTS; k++) begin
				dout[k] <= '0;
			end
		end else if (capture) begin
			for (int k = 0; k < gpu_ram_pkg::NUM_PORTS; k++) begin
				dout[k] <= pipe[TOP - k];
			end
		end
	end

endmodule

// ==== hw/gpu_pixel_ram.sv ====
`timescale 1ns/10ps

module gpu_pixel_ram (
	input  logic                    clk,
	input  logic                    reset,
	input  gpu_ram_pkg::addr_t      addr_in  [gpu_ram_pkg::NUM_PORTS],
	input  gpu_ram_pkg::cmd_t       cmd_in   [gpu_ram_pkg::NUM_PORTS],
	output gpu_ram_pkg::addr_t      addr_out [gpu_ram_pkg::NUM_PORTS], // 10 clk after sample
	output gpu_ram_pkg::cmd_t       cmd_out  [gpu_ram_pkg::NUM_PORTS],
	output gpu_ram_pkg::pix_t       data_out [gpu_ram_pkg::NUM_PORTS],
	output logic                    pix_valid,
	input  gpu_ram_pkg::addr_t      host_addr,
	input  logic                    host_wr,
	input  gpu_ram_pkg::host_byte_t host_wdata,
	output gpu_ram_pkg::host_byte_t host_rdata
);

	gpu_ram_pkg::phase_t phase;
	logic                pixel_start;

	gpu_ram_pkg::addr_t  ram_addr;       // mux -> RAM
	gpu_ram_pkg::cmd_t   ram_cmd;
	gpu_ram_pkg::addr_t  video_addr_out; // RAM -> realign pipes
	gpu_ram_pkg::cmd_t   video_cmd_out;
	gpu_ram_pkg::pix_t   video_data;

	pixel_phase_ctrl i_ctrl (
		.clk         (clk),
		.reset       (reset),
		.phase       (phase),
		.pixel_start (pixel_start),
		.pix_valid   (pix_valid)
	);

	port_mux i_mux (
		.clk         (clk),
		.reset       (reset),
		.phase       (phase),
		.pixel_start (pixel_start),
		.addr_in     (addr_in),
		.cmd_in      (cmd_in),
		.ram_addr    (ram_addr),
		.ram_cmd     (ram_cmd)
	);

	gpu_dual_port_ram i_ram (
		.clk            (clk),
		.video_addr     (ram_addr),
		.video_cmd      (ram_cmd),
		.video_addr_out (video_addr_out),
		.video_cmd_out  (video_cmd_out),
		.video_data     (video_data),
		.host_addr      (host_addr),   // host port straight from the pins
		.host_wr        (host_wr),
		.host_wdata     (host_wdata),
		.host_rdata     (host_rdata)
	);

	realign_pipe #(.payload_t(gpu_ram_pkg::pix_t)) i_data_pipe (
		.clk     (clk),
		.reset   (reset),
		.capture (pixel_start),
		.din     (video_data),
		.dout    (data_out)
	);

	realign_pipe #(.payload_t(gpu_ram_pkg::addr_t)) i_addr_pipe (
		.clk     (clk),
		.reset   (reset),
		.capture (pixel_start),
		.din     (video_addr_out),
		.dout    (addr_out)
	);

	realign_pipe #(.payload_t(gpu_ram_pkg::cmd_t)) i_cmd_pipe (
		.clk     (clk),
		.reset   (reset),
		.capture (pixel_start),
		.din     (video_cmd_out),
		.dout    (cmd_out)
	);

endmodule

// ==== verif/tb_gpu_pixel_ram.sv ====
`timescale 1ns/10ps

module tb_gpu_pixel_ram;

	localparam int NP        = gpu_ram_pkg::NUM_PORTS;
	localparam int LATENCY   = (gpu_ram_pkg::PIXEL_PIPE - 1) * NP; // sample edge to output edge
	localparam int DRIVE_DLY = 1;                                  // ns after the rising edge

	logic                    clk;
	logic                    reset;
	gpu_ram_pkg::addr_t      addr_in  [NP];
	gpu_ram_pkg::cmd_t       cmd_in   [NP];
	gpu_ram_pkg::addr_t      addr_out [NP];
	gpu_ram_pkg::cmd_t       cmd_out  [NP];
	gpu_ram_pkg::pix_t       data_out [NP];
	logic                    pix_valid;
	gpu_ram_pkg::addr_t      host_addr;
	logic                    host_wr;
	gpu_ram_pkg::host_byte_t host_wdata;
	gpu_ram_pkg::host_byte_t host_rdata;

	string                   lines [$];            // test lines, comments stripped
	int                      cyc;                  // index of the next rising edge after reset
	int                      cycle_cnt;            // all rising edges
	int                      cycle_limit = 100;    // raised once the test file is read
	int unsigned             lcg_state;

	int                      exp_sample [$];       // sample edge of each pending pixel
	gpu_ram_pkg::addr_t      exp_addr   [$];       // five per pending pixel
	gpu_ram_pkg::cmd_t       exp_cmd    [$];
	gpu_ram_pkg::pix_t       exp_data   [$];

	gpu_pixel_ram i_dut (
		.clk        (clk),
		.reset      (reset),
		.addr_in    (addr_in),
		.cmd_in     (cmd_in),
		.addr_out   (addr_out),
		.cmd_out    (cmd_out),
		.data_out   (data_out),
		.pix_valid  (pix_valid),
		.host_addr  (host_addr),
		.host_wr    (host_wr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

	always #2 clk = ~clk;  // 4 ns period

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_pix(input gpu_ram_pkg::pix_t got, input gpu_ram_pkg::pix_t exp,
		input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_addr(input gpu_ram_pkg::addr_t got, input gpu_ram_pkg::addr_t exp,
		input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_cmd(input gpu_ram_pkg::cmd_t got, input gpu_ram_pkg::cmd_t exp,
		input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_host(input gpu_ram_pkg::host_byte_t got,
		input gpu_ram_pkg::host_byte_t exp, input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %0d ns: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	function automatic gpu_ram_pkg::cmd_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return gpu_ram_pkg::cmd_t'(lcg_state);
	endfunction

	// all stimulus moves through here, keeps cyc in step with the DUT phase
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
		cyc++;
	endtask

	task automatic host_write(input gpu_ram_pkg::addr_t a, input gpu_ram_pkg::host_byte_t d);
		host_addr  = a;
		host_wr    = 1'b1;
		host_wdata = d;
		next_cycle();
		host_wr    = 1'b0;
	endtask

	task automatic host_read(input gpu_ram_pkg::addr_t a, input gpu_ram_pkg::host_byte_t exp);
		host_addr = a;
		host_wr   = 1'b0;
		next_cycle();                   // registered read byte
		check_host(host_rdata, exp, $sformatf("host_rdata at %h", a));
	endtask

	task automatic drive_pixel(input gpu_ram_pkg::addr_t a [NP], input gpu_ram_pkg::cmd_t c [NP],
		input gpu_ram_pkg::pix_t d [NP]);
		while ((cyc % NP) != 0) begin
			next_cycle();               // next edge must be a pixel start
		end
		exp_sample.push_back(cyc);
		for (int k = 0; k < NP; k++) begin
			addr_in[k] = a[k];
			cmd_in[k]  = c[k];
			exp_addr.push_back(a[k]);   // address and command come back unchanged
			exp_cmd.push_back(c[k]);
			exp_data.push_back(d[k]);
		end
		next_cycle();
	endtask

	task automatic run_line(input string line);
		logic [31:0]        kind;
		logic [31:0]        f [15];
		gpu_ram_pkg::addr_t a [NP];
		gpu_ram_pkg::cmd_t  c [NP];
		gpu_ram_pkg::pix_t  d [NP];
		int                 n;
		kind = '0;
		n = $sscanf(line, "%s", kind);
		if (kind == 32'("W")) begin
			n = $sscanf(line, "%s %h %h", kind, f[0], f[1]);
			if (n != 3) stop_with_failure($sformatf("bad write line in test file: %s", line));
			host_write(gpu_ram_pkg::addr_t'(f[0]), gpu_ram_pkg::host_byte_t'(f[1]));
		end else if (kind == 32'("R")) begin
			n = $sscanf(line, "%s %h %h", kind, f[0], f[1]);
			if (n != 3) stop_with_failure($sformatf("bad read line in test file: %s", line));
			host_read(gpu_ram_pkg::addr_t'(f[0]), gpu_ram_pkg::host_byte_t'(f[1]));
		end else if (kind == 32'("V")) begin
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", kind,
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], f[14]);
			if (n != 16) stop_with_failure($sformatf("bad pixel line in test file: %s", line));
			for (int k = 0; k < NP; k++) begin
				a[k] = gpu_ram_pkg::addr_t'(f[k]);
				c[k] = f[NP + k];
				d[k] = gpu_ram_pkg::pix_t'(f[2*NP + k]);
			end
			drive_pixel(a, c, d);
		end else if (kind == 32'("V*")) begin
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", kind,
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
			if (n != 11) stop_with_failure($sformatf("bad pixel line in test file: %s", line));
			for (int k = 0; k < NP; k++) begin
				a[k] = gpu_ram_pkg::addr_t'(f[k]);
				c[k] = lcg_next();      // commands only need to survive the trip
				d[k] = gpu_ram_pkg::pix_t'(f[NP + k]);
			end
			drive_pixel(a, c, d);
		end else begin
			stop_with_failure($sformatf("unknown line kind in test file: %s", line));
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		int   n;
		int   s;
		logic want_valid;
		if (!reset) begin
			n = cyc - 1;                // rising edge just passed
			want_valid = (n >= LATENCY) && ((n % NP) == 0);
			check_flag(pix_valid, want_valid, $sformatf("pix_valid after edge %0d", n));
			if (n < LATENCY) begin
				for (int k = 0; k < NP; k++) begin  // pipeline not filled yet
					check_addr(addr_out[k], '0, $sformatf("addr_out[%0d] after reset", k));
					check_cmd(cmd_out[k], '0, $sformatf("cmd_out[%0d] after reset", k));
					check_pix(data_out[k], '0, $sformatf("data_out[%0d] after reset", k));
				end
			end
			if (pix_valid) begin
				s = n - LATENCY;            // sample edge of this result
				if ((exp_sample.size() > 0) && (exp_sample[0] < s)) begin
					stop_with_failure($sformatf("pixel sampled at edge %0d never came out",
						exp_sample[0]));
				end
				if ((exp_sample.size() > 0) && (exp_sample[0] == s)) begin
					void'(exp_sample.pop_front());
					for (int k = 0; k < NP; k++) begin
						check_addr(addr_out[k], exp_addr.pop_front(),
							$sformatf("addr_out[%0d] of sample %0d", k, s));
						check_cmd(cmd_out[k], exp_cmd.pop_front(),
							$sformatf("cmd_out[%0d] of sample %0d", k, s));
						check_pix(data_out[k], exp_data.pop_front(),
							$sformatf("data_out[%0d] of sample %0d", k, s));
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			stop_with_failure($sformatf("timeout: the run did not end within %0d clock cycles",
				cycle_limit));
		end
	end

	initial begin
		int    fd;
		int    n;
		string line;
		clk        = 1'b0;
		reset      = 1'b1;
		host_addr  = '0;
		host_wr    = 1'b0;
		host_wdata = '0;
		for (int k = 0; k < NP; k++) begin
			addr_in[k] = '0;
			cmd_in[k]  = '0;
		end
		cyc       = 0;
		cycle_cnt = 0;
		lcg_state = 1;

		fd = $fopen("verif/gpu_ram_tests.txt", "r");
		if (fd == 0) stop_with_failure("could not open verif/gpu_ram_tests.txt");
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if ((n > 1) && (line.getc(0) != "#")) begin
				lines.push_back(line);  // skip comments and blank lines
			end
		end
		$fclose(fd);
		cycle_limit = 20 * lines.size() + 100;

		repeat (8) @(posedge clk);
		#DRIVE_DLY;
		reset = 1'b0;                   // next edge is the first pixel start

		foreach (lines[i]) begin
			run_line(lines[i]);
		end
		while (exp_sample.size() > 0) begin
			next_cycle();               // drain pixels still in flight
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== verif/gpu_ram_tests.txt ====
# W <host addr> <byte>   R <host addr> <expected byte>   all values hex
# V <addr 0..4> <cmd 0..4> <expected data 0..4>   V* has no commands, they are generated
W 08000 11
W 08001 22
W 08002 33
W 08003 44
W 08010 a5
W 08011 5a
W 08100 de
W 08101 ad
W 08222 be
W 08223 ef
W 087fe 01
W 087ff 80
W 00010 ff
W 18011 77
R 08000 11
R 08001 22
R 08002 33
R 08003 44
R 08010 a5
R 08011 5a
R 00010 00
R 18011 00
R 087fe 01
R 087ff 80
R 08101 ad
W 08101 c3
R 08101 c3
R 08100 de
V 08000 08002 08010 08100 08222 00000001 00000002 00000003 00000004 00000005 2211 4433 5aa5 c3de efbe
V 087ff 08011 00223 08001 08101 a0000000 b1111111 c2222222 d3333333 e4444444 8001 5aa5 efbe 2211 c3de
V 08222 08100 08010 08002 08000 ffffffff 00000000 deadbeef 12345678 80000001 efbe c3de 5aa5 4433 2211
V* 087fe 087fe 08003 08002 08011 8001 8001 4433 4433 5aa5
V* 08003 08000 087ff 08223 08101 4433 2211 8001 efbe c3de
V 08010 08010 08010 08010 08010 0000ffff ffff0000 a5a5a5a5 5a5a5a5a 00000000 5aa5 5aa5 5aa5 5aa5 5aa5
V* 70100 f07ff 10001 00002 3f811 c3de 8001 2211 4433 5aa5
R 08222 be
R 087fe 01
R 38000 00

// ==== list.f ====
hw/gpu_ram_pkg.sv
hw/pixel_phase_ctrl.sv
hw/port_mux.sv
hw/gpu_dual_port_ram.sv
hw/realign_pipe.sv
hw/gpu_pixel_ram.sv
verif/tb_gpu_pixel_ram.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

TOP=tb_gpu_pixel_ram
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" \
	-f list.f \
	-o "sim_$TOP"

./obj_dir/"sim_$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Result: PASSED" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi
